//--- gsau_pkg.sv
package gsau_pkg;

  // array geometry
  localparam int SA_DIM = 4;

  // element widths
  localparam int ACT_W = 8;
  localparam int PSUM_W = 24;
  // full product of two signed activations/weights
  localparam int PROD_W = 2 * ACT_W;

  // multiply accept to output buffer write
  localparam int SA_LATENCY = 3;

  // array output buffer
  localparam int SA_OBUF_DEPTH = 4;
  localparam int OBUF_PTR_W = $clog2(SA_OBUF_DEPTH);
  localparam int OBUF_CNT_W = $clog2(SA_OBUF_DEPTH + 1);

  // destination register FIFO
  localparam int DST_FIFO_DEPTH = 4;
  localparam int DST_PTR_W = $clog2(DST_FIFO_DEPTH);
  localparam int DST_CNT_W = $clog2(DST_FIFO_DEPTH + 1);

  // index widths
  localparam int VREG_IDX_W = 8;
  localparam int ROW_IDX_W = $clog2(SA_DIM);

  // vector register index that also carries the weight row on loads
  typedef logic [VREG_IDX_W-1:0] vreg_idx_t;

  // four activations or one weight row with element k at bits k*ACT_W
  typedef logic [SA_DIM*ACT_W-1:0] act_vec_t;

  // four partial sums with element k at bits k*PSUM_W
  typedef logic [SA_DIM*PSUM_W-1:0] psum_vec_t;

  // weight row select
  typedef logic [ROW_IDX_W-1:0] row_idx_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
  import gsau_pkg::*;
(
  input  logic      CLK,
  input  logic      i_reset,
  input  logic      i_wr_en,
  input  logic      i_shift,
  input  vreg_idx_t i_din,
  output vreg_idx_t o_dout,
  output logic      o_empty,
  output logic      o_full
);

  // entry storage
  vreg_idx_t mem [DST_FIFO_DEPTH];

  logic [DST_PTR_W-1:0] wr_ptr;
  logic [DST_PTR_W-1:0] rd_ptr;
  logic [DST_CNT_W-1:0] count;

  assign o_empty = (count == '0);
  assign o_full  = (count == DST_CNT_W'(DST_FIFO_DEPTH));

  // head is visible right away
  assign o_dout = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at the last entry
      if (i_wr_en) begin
        wr_ptr <= (wr_ptr == DST_PTR_W'(DST_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_shift) begin
        rd_ptr <= (rd_ptr == DST_PTR_W'(DST_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({i_wr_en, i_shift})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // upstream ready must hold off pushes once full
  a_no_write_full: assert property (@(posedge CLK) disable iff (i_reset)
    !(i_wr_en && o_full)) else $error("sync_fifo: write while full");

  // every array result must have a destination waiting
  a_no_shift_empty: assert property (@(posedge CLK) disable iff (i_reset)
    !(i_shift && o_empty)) else $error("sync_fifo: shift while empty");

endmodule

//--- gsau_control_unit.sv
`timescale 1ns/1ps

module gsau_control_unit
  import gsau_pkg::*;
(
  input  logic      CLK,
  input  logic      i_reset,
  // scoreboard
  input  logic      i_sb_valid,
  input  logic      i_sb_weight,
  input  vreg_idx_t i_sb_vdst,
  // veggie file
  input  logic      i_veg_valid,
  input  act_vec_t  i_veg_vs1,
  input  psum_vec_t i_veg_vs2,
  output logic      o_sb_ready,
  // to the array
  output logic      o_sa_weight_en,
  output logic      o_sa_input_en,
  output row_idx_t  o_sa_weight_row,
  output act_vec_t  o_sa_array_in,
  output psum_vec_t o_sa_array_in_partials,
  // from the array
  input  logic      i_sa_fifo_has_space,
  input  logic      i_sa_out_valid,
  input  psum_vec_t i_sa_array_output,
  output logic      o_sa_output_ready,
  // writeback side
  input  logic      i_wb_output_ready,
  output logic      o_wb_valid,
  output psum_vec_t o_wb_psum,
  output vreg_idx_t o_wb_wbdst
);

  logic      accept;
  logic      fifo_wr;
  logic      fifo_shift;
  logic      fifo_empty;
  logic      fifo_full;
  vreg_idx_t fifo_dout;

  // destinations of multiplies still in flight
  sync_fifo dst_fifo (
    .CLK     (CLK),
    .i_reset (i_reset),
    .i_wr_en (fifo_wr),
    .i_shift (fifo_shift),
    .i_din   (i_sb_vdst),
    .o_dout  (fifo_dout),
    .o_empty (fifo_empty),
    .o_full  (fifo_full)
  );

  always_comb begin
    // ready from internal state only
    o_sb_ready = !fifo_full && i_sa_fifo_has_space;
    accept     = i_sb_valid && i_veg_valid && o_sb_ready;

    // vs1 carries activations or a weight row and vs2 the partials
    o_sa_array_in          = i_veg_vs1;
    o_sa_array_in_partials = i_veg_vs2;
    // weight loads reuse vdst as the row number
    o_sa_weight_row        = i_sb_vdst[ROW_IDX_W-1:0];

    o_sa_weight_en = accept && i_sb_weight;
    o_sa_input_en  = accept && !i_sb_weight;
    // only multiplies produce a result, so only they need a destination
    fifo_wr        = o_sa_input_en;

    // array drains straight into writeback
    o_sa_output_ready = i_wb_output_ready;
    fifo_shift        = i_sa_out_valid && i_wb_output_ready;

    // pair result with oldest destination
    o_wb_valid = i_sa_out_valid;
    o_wb_psum  = i_sa_array_output;
    o_wb_wbdst = fifo_dout;
  end

  // result order in the array must match push order here
  a_result_has_dst: assert property (@(posedge CLK) disable iff (i_reset)
    i_sa_out_valid |-> !fifo_empty) else $error("gsau_control_unit: result without vdst");

endmodule

//--- sys_array.sv
`timescale 1ns/1ps

module sys_array
  import gsau_pkg::*;
(
  input  logic      CLK,
  input  logic      i_reset,
  input  logic      i_weight_en,
  input  logic      i_input_en,
  input  row_idx_t  i_weight_row,
  input  act_vec_t  i_array_in,
  input  psum_vec_t i_array_in_partials,
  output logic      o_fifo_has_space,
  output logic      o_out_valid,
  output psum_vec_t o_array_output,
  input  logic      i_output_ready
);

  // weight-stationary storage where row i meets activation i
  logic signed [ACT_W-1:0] weight_q [SA_DIM][SA_DIM];

  // one valid bit per pipeline stage
  logic [SA_LATENCY-1:0] valid_pipe;

  // stage one operands
  act_vec_t  s1_act;
  psum_vec_t s1_psum;
  // stage two products
  logic signed [PROD_W-1:0] s2_prod [SA_DIM][SA_DIM];
  psum_vec_t s2_psum;
  // stage three results
  logic [PSUM_W-1:0] col_sum [SA_DIM];
  psum_vec_t s3_result;

  // output buffer
  psum_vec_t obuf [SA_OBUF_DEPTH];
  logic [OBUF_PTR_W-1:0] obuf_wr_ptr;
  logic [OBUF_PTR_W-1:0] obuf_rd_ptr;
  logic [OBUF_CNT_W-1:0] obuf_count;
  logic [OBUF_CNT_W-1:0] inflight;
  logic obuf_push;
  logic obuf_pop;

  // new weight visible to a multiply accepted next cycle
  always_ff @(posedge CLK) begin
    if (i_weight_en) begin
      for (int j = 0; j < SA_DIM; j++) begin
        weight_q[i_weight_row][j] <= i_array_in[j*ACT_W +: ACT_W];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (i_reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[SA_LATENCY-2:0], i_input_en};
    end
  end

  // payload stages advance with their valid bits
  always_ff @(posedge CLK) begin
    if (i_input_en) begin
      s1_act  <= i_array_in;
      s1_psum <= i_array_in_partials;
    end
    if (valid_pipe[0]) begin
      for (int i = 0; i < SA_DIM; i++) begin
        for (int j = 0; j < SA_DIM; j++) begin
          s2_prod[i][j] <= $signed(s1_act[i*ACT_W +: ACT_W]) * weight_q[i][j];
        end
      end
      s2_psum <= s1_psum;
    end
    if (valid_pipe[1]) begin
      for (int j = 0; j < SA_DIM; j++) begin
        s3_result[j*PSUM_W +: PSUM_W] <= col_sum[j];
      end
    end
  end

  // column sums of sign-extended products wrap mod 2^PSUM_W
  always_comb begin
    for (int j = 0; j < SA_DIM; j++) begin
      col_sum[j] = s2_psum[j*PSUM_W +: PSUM_W];
      for (int i = 0; i < SA_DIM; i++) begin
        col_sum[j] = col_sum[j] + {{(PSUM_W-PROD_W){s2_prod[i][j][PROD_W-1]}}, s2_prod[i][j]};
      end
    end
  end

  assign obuf_push = valid_pipe[SA_LATENCY-1];
  assign obuf_pop  = o_out_valid && i_output_ready;

  always_ff @(posedge CLK) begin
    if (obuf_push) begin
      obuf[obuf_wr_ptr] <= s3_result;
    end
  end

  always_ff @(posedge CLK) begin
    if (i_reset) begin
      obuf_wr_ptr <= '0;
      obuf_rd_ptr <= '0;
      obuf_count  <= '0;
    end else begin
      if (obuf_push) begin
        obuf_wr_ptr <= obuf_wr_ptr + 1'b1;
      end
      if (obuf_pop) begin
        obuf_rd_ptr <= obuf_rd_ptr + 1'b1;
      end
      obuf_count <= obuf_count + OBUF_CNT_W'(obuf_push) - OBUF_CNT_W'(obuf_pop);
    end
  end

  assign o_out_valid    = (obuf_count != '0);
  assign o_array_output = obuf[obuf_rd_ptr];

  // reserve a slot for everything still in the pipe
  assign inflight         = OBUF_CNT_W'($countones(valid_pipe));
  assign o_fifo_has_space = (obuf_count + inflight) < SA_OBUF_DEPTH;

  // has_space must cover every multiply accepted three edges ago
  a_obuf_no_overflow: assert property (@(posedge CLK) disable iff (i_reset)
    obuf_push |-> (obuf_count < SA_OBUF_DEPTH) || obuf_pop)
    else $error("sys_array: output buffer overflow");

endmodule

//--- wb_buffer.sv
`timescale 1ns/1ps

module wb_buffer
  import gsau_pkg::*;
(
  input  logic      CLK,
  input  logic      i_reset,
  input  logic      i_valid,
  input  psum_vec_t i_psum,
  input  vreg_idx_t i_wbdst,
  output logic      o_ready,
  output logic      o_wb_valid,
  output psum_vec_t o_wb_psum,
  output vreg_idx_t o_wb_wbdst,
  input  logic      i_wb_ready
);

  logic      full_q;
  psum_vec_t psum_q;
  vreg_idx_t wbdst_q;
  logic      capture;

  // ready when empty or when the held entry leaves this cycle
  assign o_ready = !full_q || i_wb_ready;
  assign capture = i_valid && o_ready;

  always_ff @(posedge CLK) begin
    if (i_reset) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (i_wb_ready) begin
      // consumed with nothing behind it
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      psum_q  <= i_psum;
      wbdst_q <= i_wbdst;
    end
  end

  assign o_wb_valid = full_q;
  assign o_wb_psum  = psum_q;
  assign o_wb_wbdst = wbdst_q;

  // stalled result must not change under the consumer
  a_hold_stable: assert property (@(posedge CLK) disable iff (i_reset)
    o_wb_valid && !i_wb_ready |=> o_wb_valid && $stable(o_wb_psum) && $stable(o_wb_wbdst))
    else $error("wb_buffer: data changed while stalled");

endmodule

//--- gsau_top.sv
`timescale 1ns/1ps

module gsau_top
  import gsau_pkg::*;
(
  input  logic      CLK,
  input  logic      i_reset,
  input  logic      i_sb_valid,
  input  logic      i_sb_weight,
  input  vreg_idx_t i_sb_vdst,
  input  logic      i_veg_valid,
  input  act_vec_t  i_veg_vs1,
  input  psum_vec_t i_veg_vs2,
  output logic      o_sb_ready,
  output logic      o_wb_valid,
  output psum_vec_t o_wb_psum,
  output vreg_idx_t o_wb_wbdst,
  input  logic      i_wb_ready
);

  // control unit to array
  logic      sa_weight_en;
  logic      sa_input_en;
  row_idx_t  sa_weight_row;
  act_vec_t  sa_array_in;
  psum_vec_t sa_array_in_partials;
  logic      sa_output_ready;
  // array back to control unit
  logic      sa_fifo_has_space;
  logic      sa_out_valid;
  psum_vec_t sa_array_output;
  // control unit to writeback
  logic      wb_in_valid;
  psum_vec_t wb_in_psum;
  vreg_idx_t wb_in_wbdst;
  logic      wb_in_ready;

  // input side, decode and destination tracking
  gsau_control_unit u_ctrl (
    .CLK                    (CLK),
    .i_reset                (i_reset),
    .i_sb_valid             (i_sb_valid),
    .i_sb_weight            (i_sb_weight),
    .i_sb_vdst              (i_sb_vdst),
    .i_veg_valid            (i_veg_valid),
    .i_veg_vs1              (i_veg_vs1),
    .i_veg_vs2              (i_veg_vs2),
    .o_sb_ready             (o_sb_ready),
    .o_sa_weight_en         (sa_weight_en),
    .o_sa_input_en          (sa_input_en),
    .o_sa_weight_row        (sa_weight_row),
    .o_sa_array_in          (sa_array_in),
    .o_sa_array_in_partials (sa_array_in_partials),
    .i_sa_fifo_has_space    (sa_fifo_has_space),
    .i_sa_out_valid         (sa_out_valid),
    .i_sa_array_output      (sa_array_output),
    .o_sa_output_ready      (sa_output_ready),
    .i_wb_output_ready      (wb_in_ready),
    .o_wb_valid             (wb_in_valid),
    .o_wb_psum              (wb_in_psum),
    .o_wb_wbdst             (wb_in_wbdst)
  );

  sys_array u_array (
    .CLK                 (CLK),
    .i_reset             (i_reset),
    .i_weight_en         (sa_weight_en),
    .i_input_en          (sa_input_en),
    .i_weight_row        (sa_weight_row),
    .i_array_in          (sa_array_in),
    .i_array_in_partials (sa_array_in_partials),
    .o_fifo_has_space    (sa_fifo_has_space),
    .o_out_valid         (sa_out_valid),
    .o_array_output      (sa_array_output),
    .i_output_ready      (sa_output_ready)
  );

  // output side holding register
  wb_buffer u_wb (
    .CLK        (CLK),
    .i_reset    (i_reset),
    .i_valid    (wb_in_valid),
    .i_psum     (wb_in_psum),
    .i_wbdst    (wb_in_wbdst),
    .o_ready    (wb_in_ready),
    .o_wb_valid (o_wb_valid),
    .o_wb_psum  (o_wb_psum),
    .o_wb_wbdst (o_wb_wbdst),
    .i_wb_ready (i_wb_ready)
  );

endmodule

//--- tb_gsau_top.sv
`timescale 1ns/1ps

module tb_gsau_top
  import gsau_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int REC_MAX = 64;
  localparam int STALL_CYCLES = 40;
  localparam int CYCLES_PER_REC = 60;
  localparam int TIMEOUT_MARGIN = 100;
  // four in the array plus one held in writeback
  localparam int MAX_OUTSTANDING = DST_FIFO_DEPTH + 1;

  // record layout with the expected sums in the low bits
  localparam int EXP_LSB = 0;
  localparam int PART_LSB = SA_DIM * PSUM_W;
  localparam int ACT_LSB = PART_LSB + SA_DIM * PSUM_W;
  localparam int VDST_LSB = ACT_LSB + SA_DIM * ACT_W;
  localparam int KIND_LSB = VDST_LSB + VREG_IDX_W;
  localparam int REC_W = KIND_LSB + 4;

  localparam logic [3:0] KIND_END = 4'h0;
  localparam logic [3:0] KIND_WEIGHT = 4'h1;
  localparam logic [3:0] KIND_MUL = 4'h2;
  localparam logic [3:0] KIND_STALL = 4'h3;

  logic      CLK;
  logic      i_reset;
  logic      i_sb_valid;
  logic      i_sb_weight;
  vreg_idx_t i_sb_vdst;
  logic      i_veg_valid;
  act_vec_t  i_veg_vs1;
  psum_vec_t i_veg_vs2;
  logic      o_sb_ready;
  logic      o_wb_valid;
  psum_vec_t o_wb_psum;
  vreg_idx_t o_wb_wbdst;
  logic      i_wb_ready;

  logic [REC_W-1:0] rec_mem [REC_MAX];
  int n_records;
  int n_expected;
  int n_checked;
  int outstanding;
  bit load_done;
  bit reset_done;
  bit hold_wb;

  // results still owed by the DUT in issue order
  psum_vec_t exp_psum_q [$];
  vreg_idx_t exp_vdst_q [$];

  int unsigned lcg_state = 47;

  gsau_top gsau_top_inst (
    .CLK         (CLK),
    .i_reset     (i_reset),
    .i_sb_valid  (i_sb_valid),
    .i_sb_weight (i_sb_weight),
    .i_sb_vdst   (i_sb_vdst),
    .i_veg_valid (i_veg_valid),
    .i_veg_vs1   (i_veg_vs1),
    .i_veg_vs2   (i_veg_vs2),
    .o_sb_ready  (o_sb_ready),
    .o_wb_valid  (o_wb_valid),
    .o_wb_psum   (o_wb_psum),
    .o_wb_wbdst  (o_wb_wbdst),
    .i_wb_ready  (i_wb_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_psum(input string name, input psum_vec_t got, input psum_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_vdst(input string name, input vreg_idx_t got, input vreg_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERROR time=%0t %s got=%b expected=%b", $time, name, got, exp));
    end
  endtask

  task automatic load_records();
    logic [3:0] kind;
    for (int r = 0; r < REC_MAX; r++) begin
      rec_mem[r] = '0;
    end
    $readmemh("gsau_input.txt", rec_mem);
    n_records = 0;
    n_expected = 0;
    // zero kind marks the end of the file
    while (n_records < REC_MAX && rec_mem[n_records][KIND_LSB +: 4] != KIND_END) begin
      kind = rec_mem[n_records][KIND_LSB +: 4];
      if (kind == KIND_MUL) begin
        n_expected++;
      end else if (kind != KIND_WEIGHT && kind != KIND_STALL) begin
        abort_run("gsau_input.txt holds a record of unknown kind");
      end
      n_records++;
    end
    if (n_expected == 0) begin
      abort_run("gsau_input.txt is missing or holds no multiply records");
    end
    load_done = 1'b1;
  endtask

  // called and returns at a falling edge with both valids low
  task automatic feed_records();
    logic [REC_W-1:0] rec;
    logic [3:0] kind;
    int gap;
    for (int r = 0; r < n_records; r++) begin
      rec = rec_mem[r];
      kind = rec[KIND_LSB +: 4];
      if (kind == KIND_STALL) begin
        hold_wb = 1'b1;
      end else begin
        // idle gap of zero to two cycles
        gap = int'(next_rand() % 3);
        repeat (gap) @(negedge CLK);
        i_sb_valid  = 1'b1;
        i_veg_valid = 1'b1;
        i_sb_weight = (kind == KIND_WEIGHT);
        i_sb_vdst   = rec[VDST_LSB +: VREG_IDX_W];
        i_veg_vs1   = rec[ACT_LSB +: SA_DIM * ACT_W];
        i_veg_vs2   = rec[PART_LSB +: SA_DIM * PSUM_W];
        // ready seen before the edge decides the accept
        do begin
          @(posedge CLK);
        end while (!o_sb_ready);
        if (kind == KIND_MUL) begin
          exp_vdst_q.push_back(rec[VDST_LSB +: VREG_IDX_W]);
          exp_psum_q.push_back(rec[EXP_LSB +: SA_DIM * PSUM_W]);
          outstanding++;
          if (outstanding > MAX_OUTSTANDING) begin
            abort_run("more multiplies accepted than the unit can hold");
          end
        end
        @(negedge CLK);
        i_sb_valid  = 1'b0;
        i_veg_valid = 1'b0;
      end
    end
  endtask

  initial begin : main_seq
    i_reset     = 1'b1;
    i_sb_valid  = 1'b0;
    i_sb_weight = 1'b0;
    i_sb_vdst   = '0;
    i_veg_valid = 1'b0;
    i_veg_vs1   = '0;
    i_veg_vs2   = '0;
    i_wb_ready  = 1'b0;
    load_records();
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    i_reset = 1'b0;
    // state right after reset
    @(posedge CLK);
    check_flag("o_wb_valid", o_wb_valid, 1'b0);
    check_flag("o_sb_ready", o_sb_ready, 1'b1);
    @(negedge CLK);
    reset_done = 1'b1;
    feed_records();
    wait (n_checked == n_expected);
    // give a duplicate result time to show up
    repeat (8) @(posedge CLK);
    if (exp_psum_q.size() == 0 && !o_wb_valid) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("results left over after the last record was checked");
    end
  end

  initial begin : result_check
    vreg_idx_t exp_vdst;
    psum_vec_t exp_psum;
    wait (reset_done);
    forever begin
      @(posedge CLK);
      if (o_wb_valid && i_wb_ready) begin
        if (exp_psum_q.size() == 0) begin
          abort_run("result delivered with no multiply outstanding");
        end else begin
          exp_vdst = exp_vdst_q.pop_front();
          exp_psum = exp_psum_q.pop_front();
          check_vdst("o_wb_wbdst", o_wb_wbdst, exp_vdst);
          check_psum("o_wb_psum", o_wb_psum, exp_psum);
          n_checked++;
          outstanding--;
        end
      end
    end
  end

  initial begin : wb_ready_drive
    bit blocked;
    wait (reset_done);
    forever begin
      @(negedge CLK);
      if (hold_wb) begin
        // consumer stalled so issue must back up
        i_wb_ready = 1'b0;
        blocked = 1'b0;
        repeat (STALL_CYCLES) begin
          @(posedge CLK);
          if (!o_sb_ready) begin
            blocked = 1'b1;
          end
          @(negedge CLK);
        end
        if (!blocked) begin
          abort_run("o_sb_ready never dropped while writeback was stalled");
        end
        hold_wb = 1'b0;
      end else begin
        // ready about three cycles in four
        i_wb_ready = (next_rand() % 4) != 0;
      end
    end
  end

  initial begin : watchdog
    wait (load_done);
    #((n_records * CYCLES_PER_REC + TIMEOUT_MARGIN) * CLK_PERIOD);
    abort_run("timeout, results stopped arriving");
  end

endmodule

//--- gsau_top.f
gsau_pkg.sv
sync_fifo.sv
gsau_control_unit.sv
sys_array.sv
wb_buffer.sv
gsau_top.sv
tb_gsau_top.sv

//--- gsau_input.txt
// columns: kind _ vdst _ vs1 _ partials e3..e0 _ expected e3..e0, all hex, element 0 rightmost
// kind 1 loads weight row vdst from vs1, kind 2 multiplies, kind 3 starts a writeback stall
// identity weights
1_00_00000001_000000_000000_000000_000000_000000_000000_000000_000000
1_01_00000100_000000_000000_000000_000000_000000_000000_000000_000000
1_02_00010000_000000_000000_000000_000000_000000_000000_000000_000000
1_03_01000000_000000_000000_000000_000000_000000_000000_000000_000000
2_10_807ffd05_001000_fffff0_000000_000064_000f80_00006f_fffffd_000069
2_11_01020304_000000_000000_000000_000000_000001_000002_000003_000004
2_12_ffffffff_123456_000001_800000_7fffff_123455_000000_7fffff_7ffffe
// mixed signed weights
1_00_0003ff02_000000_000000_000000_000000_000000_000000_000000_000000
1_01_04fe0101_000000_000000_000000_000000_000000_000000_000000_000000
1_02_800100fd_000000_000000_000000_000000_000000_000000_000000_000000
1_03_7f000205_000000_000000_000000_000000_000000_000000_000000_000000
2_20_04030201_000000_000000_000000_000000_000084_000002_000009_00000f
2_21_fcfdfeff_000100_000000_fffff6_000010_00007c_fffffe_ffffed_000001
2_22_7f80807f_000000_000000_000000_000000_007d01_0001fd_ffffff_000479
// wraps past the top of the 24-bit range
2_23_01000000_7fff90_800000_000000_7ffffc_80000f_800000_000002_800001
// reload row 2, second multiply has activation 2 at zero
1_02_01010101_000000_000000_000000_000000_000000_000000_000000_000000
2_24_04030201_000000_000000_000000_000000_000207_000002_00000c_00001b
2_25_07000605_000000_000000_000000_000000_000391_000003_00000f_000033
// burst while the writeback side is stalled
3_00_00000000_000000_000000_000000_000000_000000_000000_000000_000000
2_30_00000001_000000_000000_000000_000000_000000_000003_ffffff_000002
2_31_00000002_000000_000000_000000_000000_000000_000006_fffffe_000004
2_32_00000003_000000_000000_000000_000000_000000_000009_fffffd_000006
2_33_00000004_000000_000000_000000_000000_000000_00000c_fffffc_000008
2_34_00000005_000000_000000_000000_000000_000000_00000f_fffffb_00000a
2_35_00000006_000000_000000_000000_000000_000000_000012_fffffa_00000c
2_36_00000007_000000_000000_000000_000000_000000_000015_fffff9_00000e
2_37_00000008_000000_000000_000000_000000_000000_000018_fffff8_000010
// drain and resume
2_40_00000000_0a0b0c_112233_fedcba_000001_0a0b0c_112233_fedcba_000001
2_41_00000100_000000_000000_000000_000000_000004_fffffe_000001_000001
